// ==== verilog/cmd_pkg.sv ====
package cmd_pkg;

	////////////////////
	// Command word
	////////////////////

	// Opcode and address carried through each queue
	localparam int opcode_w = 8;
	localparam int addr_w   = 32;

	// Tag layout, class in the top bits, sequence below
	localparam int tag_w   = 8;
	localparam int class_w = 2;
	localparam int seq_w   = 6;

	// Class codes, also the bit index into grant and done vectors
	localparam logic [class_w-1:0] cls_read    = 2'd0;
	localparam logic [class_w-1:0] cls_write   = 2'd1;
	localparam logic [class_w-1:0] cls_wed     = 2'd2;
	localparam logic [class_w-1:0] cls_restart = 2'd3;

	////////////////////
	// Response side
	////////////////////

	// Zero code is done, anything else an error
	localparam int code_w = 8;

	// Host command credits
	localparam int credit_w     = 8;
	localparam int init_credits = 8;

	////////////////////
	// Queue sizing
	////////////////////

	// Read and write queues
	localparam int bulk_depth    = 16;
	// Wed and restart queues
	localparam int ctrl_depth    = 2;
	// Free entries left when almost_full rises
	localparam int almost_margin = 1;

endpackage

// ==== verilog/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo import cmd_pkg::*; #(
	parameter int width = 40,
	parameter int depth = 16
) (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             push,
	input  logic [width-1:0] data_in,
	input  logic             pop,
	output logic [width-1:0] data_out,
	output logic             full,
	output logic             almost_full,
	output logic             empty
);

	// Pointer and occupancy widths
	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	logic [width-1:0] mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Wrap at depth, works for any depth
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Drop push when full, drop pop when empty
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Storage, no reset
	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// Pointers and occupancy
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Show-ahead head and flags
	assign data_out    = mem[rd_ptr];
	assign empty       = (count == '0);
	assign full        = (count == cnt_w'(depth));
	assign almost_full = (count >= cnt_w'(depth - almost_margin));

endmodule

// ==== verilog/cmd_arbiter.sv ====
`timescale 1ns/1ps

module cmd_arbiter import cmd_pkg::*; (
	input  logic       read_empty,
	input  logic       write_empty,
	input  logic       wed_empty,
	input  logic       restart_empty,
	input  logic       credit_avail,
	output logic [3:0] grant
);

	////////////////////
	// Fixed priority
	////////////////////

	// Restart first, then wed, then read, then write
	// Grant is also the pop vector of the queues
	always_comb begin
		grant = '0;
		// Nothing issues without a host credit
		if (credit_avail) begin
			if (!restart_empty) begin
				grant[cls_restart] = 1'b1;
			end else if (!wed_empty) begin
				grant[cls_wed] = 1'b1;
			end else if (!read_empty) begin
				// Bulk traffic only when no control command waits
				grant[cls_read] = 1'b1;
			end else if (!write_empty) begin
				grant[cls_write] = 1'b1;
			end
		end
	end

	// At most one bit set, so one command per cycle

endmodule

// ==== verilog/credit_counter.sv ====
`timescale 1ns/1ps

module credit_counter import cmd_pkg::*; (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                issue,
	input  logic                response_valid,
	input  logic [credit_w-1:0] response_credits,
	output logic [credit_w-1:0] credit_count,
	output logic                credit_avail
);

	// Credits handed back by this response
	logic [credit_w-1:0] returned;

	assign returned = response_valid ? response_credits : '0;

	// One credit per issued command, returns added the same cycle
	always_ff @(posedge clock) begin
		if (!rst_n)
			credit_count <= credit_w'(init_credits);
		else
			credit_count <= credit_count - credit_w'(issue) + returned;
	end

	// Any credit left lets the arbiter grant
	assign credit_avail = (credit_count != '0);

endmodule

// ==== verilog/command_issue.sv ====
`timescale 1ns/1ps

module command_issue import cmd_pkg::*; (
	input  logic                clock,
	input  logic                rst_n,
	input  logic [3:0]          grant,
	input  logic [opcode_w-1:0] read_opcode,
	input  logic [opcode_w-1:0] write_opcode,
	input  logic [opcode_w-1:0] wed_opcode,
	input  logic [opcode_w-1:0] restart_opcode,
	input  logic [addr_w-1:0]   read_address,
	input  logic [addr_w-1:0]   write_address,
	input  logic [addr_w-1:0]   wed_address,
	input  logic [addr_w-1:0]   restart_address,
	output logic                command_valid,
	output logic [opcode_w-1:0] command_opcode,
	output logic [addr_w-1:0]   command_address,
	output logic [tag_w-1:0]    command_tag
);

	logic [class_w-1:0]  sel_class;
	logic [opcode_w-1:0] sel_opcode;
	logic [addr_w-1:0]   sel_address;
	logic [seq_w-1:0]    seq;
	logic                issue;

	assign issue = |grant;

	// Head mux, grant is one-hot
	always_comb begin
		sel_class   = cls_read;
		sel_opcode  = read_opcode;
		sel_address = read_address;
		if (grant[cls_write]) begin
			sel_class   = cls_write;
			sel_opcode  = write_opcode;
			sel_address = write_address;
		end else if (grant[cls_wed]) begin
			sel_class   = cls_wed;
			sel_opcode  = wed_opcode;
			sel_address = wed_address;
		end else if (grant[cls_restart]) begin
			sel_class   = cls_restart;
			sel_opcode  = restart_opcode;
			sel_address = restart_address;
		end
	end

	// Valid strobe and sequence count, wraps at 64
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			command_valid <= 1'b0;
			seq           <= '0;
		end else begin
			command_valid <= issue;
			if (issue)
				seq <= seq + 1'b1;
		end
	end

	// Bus payload, tag is class over sequence
	always_ff @(posedge clock) begin
		if (issue) begin
			command_opcode  <= sel_opcode;
			command_address <= sel_address;
			command_tag     <= {sel_class, seq};
		end
	end

endmodule

// ==== verilog/response_router.sv ====
`timescale 1ns/1ps

module response_router import cmd_pkg::*; (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              response_valid,
	input  logic [tag_w-1:0]  response_tag,
	input  logic [code_w-1:0] response_code,
	output logic              read_done,
	output logic              write_done,
	output logic              wed_done,
	output logic              restart_done,
	output logic [code_w-1:0] done_code,
	output logic [3:0]        response_error
);

	logic [class_w-1:0] resp_class;
	logic [3:0]         done_q;

	// Class lives in the top bits of the tag
	assign resp_class = response_tag[tag_w-1 -: class_w];

	////////////////////
	// Done and error
	////////////////////

	// One-cycle pulse per response, sticky error on non-zero code
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			done_q         <= '0;
			response_error <= '0;
		end else begin
			done_q <= '0;
			if (response_valid) begin
				done_q[resp_class] <= 1'b1;
				if (response_code != '0)
					response_error[resp_class] <= 1'b1;
			end
		end
	end

	// Code travels with the pulse
	always_ff @(posedge clock) begin
		if (response_valid)
			done_code <= response_code;
	end

	// Per-class pulses
	assign read_done    = done_q[cls_read];
	assign write_done   = done_q[cls_write];
	assign wed_done     = done_q[cls_wed];
	assign restart_done = done_q[cls_restart];

endmodule

// ==== verilog/command_unit.sv ====
`timescale 1ns/1ps

module command_unit import cmd_pkg::*; (
	input  logic                clock,
	input  logic                rst_n,
	// Read queue
	input  logic                read_push,
	input  logic [opcode_w-1:0] read_opcode,
	input  logic [addr_w-1:0]   read_address,
	output logic                read_full,
	output logic                read_almost_full,
	// Write queue
	input  logic                write_push,
	input  logic [opcode_w-1:0] write_opcode,
	input  logic [addr_w-1:0]   write_address,
	output logic                write_full,
	output logic                write_almost_full,
	// Wed queue
	input  logic                wed_push,
	input  logic [opcode_w-1:0] wed_opcode,
	input  logic [addr_w-1:0]   wed_address,
	output logic                wed_full,
	output logic                wed_almost_full,
	// Restart queue
	input  logic                restart_push,
	input  logic [opcode_w-1:0] restart_opcode,
	input  logic [addr_w-1:0]   restart_address,
	output logic                restart_full,
	output logic                restart_almost_full,
	// Command bus
	output logic                command_valid,
	output logic [opcode_w-1:0] command_opcode,
	output logic [addr_w-1:0]   command_address,
	output logic [tag_w-1:0]    command_tag,
	// Host responses
	input  logic                response_valid,
	input  logic [tag_w-1:0]    response_tag,
	input  logic [code_w-1:0]   response_code,
	input  logic [credit_w-1:0] response_credits,
	output logic [credit_w-1:0] credit_count,
	// Routed responses
	output logic                read_done,
	output logic                write_done,
	output logic                wed_done,
	output logic                restart_done,
	output logic [code_w-1:0]   done_code,
	output logic [3:0]          response_error
);

	// Queue heads
	logic [opcode_w-1:0] read_head_opcode;
	logic [opcode_w-1:0] write_head_opcode;
	logic [opcode_w-1:0] wed_head_opcode;
	logic [opcode_w-1:0] restart_head_opcode;
	logic [addr_w-1:0]   read_head_address;
	logic [addr_w-1:0]   write_head_address;
	logic [addr_w-1:0]   wed_head_address;
	logic [addr_w-1:0]   restart_head_address;

	// Empty flags, grant and credits
	logic       read_empty;
	logic       write_empty;
	logic       wed_empty;
	logic       restart_empty;
	logic [3:0] grant;
	logic       credit_avail;

	////////////////////
	// Command queues
	////////////////////

	// Bulk queues, deep
	cmd_fifo #(.width(opcode_w + addr_w), .depth(bulk_depth)) read_fifo (
		.clock       (clock),
		.rst_n       (rst_n),
		.push        (read_push),
		.data_in     ({read_opcode, read_address}),
		.pop         (grant[cls_read]),
		.data_out    ({read_head_opcode, read_head_address}),
		.full        (read_full),
		.almost_full (read_almost_full),
		.empty       (read_empty)
	);

	cmd_fifo #(.width(opcode_w + addr_w), .depth(bulk_depth)) write_fifo (
		.clock       (clock),
		.rst_n       (rst_n),
		.push        (write_push),
		.data_in     ({write_opcode, write_address}),
		.pop         (grant[cls_write]),
		.data_out    ({write_head_opcode, write_head_address}),
		.full        (write_full),
		.almost_full (write_almost_full),
		.empty       (write_empty)
	);

	// Control queues, shallow
	cmd_fifo #(.width(opcode_w + addr_w), .depth(ctrl_depth)) wed_fifo (
		.clock       (clock),
		.rst_n       (rst_n),
		.push        (wed_push),
		.data_in     ({wed_opcode, wed_address}),
		.pop         (grant[cls_wed]),
		.data_out    ({wed_head_opcode, wed_head_address}),
		.full        (wed_full),
		.almost_full (wed_almost_full),
		.empty       (wed_empty)
	);

	cmd_fifo #(.width(opcode_w + addr_w), .depth(ctrl_depth)) restart_fifo (
		.clock       (clock),
		.rst_n       (rst_n),
		.push        (restart_push),
		.data_in     ({restart_opcode, restart_address}),
		.pop         (grant[cls_restart]),
		.data_out    ({restart_head_opcode, restart_head_address}),
		.full        (restart_full),
		.almost_full (restart_almost_full),
		.empty       (restart_empty)
	);

	////////////////////
	// Issue path
	////////////////////

	cmd_arbiter arbiter (
		.read_empty    (read_empty),
		.write_empty   (write_empty),
		.wed_empty     (wed_empty),
		.restart_empty (restart_empty),
		.credit_avail  (credit_avail),
		.grant         (grant)
	);

	command_issue issue_stage (
		.clock           (clock),
		.rst_n           (rst_n),
		.grant           (grant),
		.read_opcode     (read_head_opcode),
		.write_opcode    (write_head_opcode),
		.wed_opcode      (wed_head_opcode),
		.restart_opcode  (restart_head_opcode),
		.read_address    (read_head_address),
		.write_address   (write_head_address),
		.wed_address     (wed_head_address),
		.restart_address (restart_head_address),
		.command_valid   (command_valid),
		.command_opcode  (command_opcode),
		.command_address (command_address),
		.command_tag     (command_tag)
	);

	// Any grant spends one credit
	credit_counter credits (
		.clock            (clock),
		.rst_n            (rst_n),
		.issue            (|grant),
		.response_valid   (response_valid),
		.response_credits (response_credits),
		.credit_count     (credit_count),
		.credit_avail     (credit_avail)
	);

	////////////////////
	// Response path
	////////////////////

	response_router router (
		.clock          (clock),
		.rst_n          (rst_n),
		.response_valid (response_valid),
		.response_tag   (response_tag),
		.response_code  (response_code),
		.read_done      (read_done),
		.write_done     (write_done),
		.wed_done       (wed_done),
		.restart_done   (restart_done),
		.done_code      (done_code),
		.response_error (response_error)
	);

endmodule

// ==== verif/command_unit_chk.sv ====
`timescale 1ns/1ps

module command_unit_chk import cmd_pkg::*; (
	input logic                clock,
	input logic                rst_n,
	input logic                command_valid,
	input logic [tag_w-1:0]    command_tag,
	input logic [credit_w-1:0] credit_count,
	input logic                response_valid,
	input logic [tag_w-1:0]    response_tag,
	input logic [code_w-1:0]   response_code,
	input logic                read_done,
	input logic                write_done,
	input logic                wed_done,
	input logic                restart_done,
	input logic [code_w-1:0]   done_code,
	input logic [3:0]          response_error,
	input logic                wed_empty,
	input logic                restart_empty
);

	// Failure count, read by the testbench at the end
	int assert_errors = 0;

	logic [3:0]         done_vec;
	logic [class_w-1:0] cmd_class;
	logic [class_w-1:0] resp_class;

	assign done_vec   = {restart_done, wed_done, write_done, read_done};
	assign cmd_class  = command_tag[tag_w-1 -: class_w];
	assign resp_class = response_tag[tag_w-1 -: class_w];

	////////////////////
	// Reset state
	////////////////////

	// First cycle out of reset
	reset_state: assert property (@(posedge clock) $rose(rst_n) |->
		!command_valid && done_vec == '0 && response_error == '0 &&
		credit_count == credit_w'(init_credits))
	else begin
		assert_errors++;
		$error("outputs not at their reset values after reset");
	end

	////////////////////
	// Issue side
	////////////////////

	// Read or write only when no control command was waiting
	control_first: assert property (@(posedge clock) disable iff (!rst_n)
		command_valid && !cmd_class[1] |-> $past(wed_empty && restart_empty))
	else begin
		assert_errors++;
		$error("read or write issued while a wed or restart command was pending");
	end

	// No issue out of an empty credit pool
	credit_gate: assert property (@(posedge clock) disable iff (!rst_n)
		command_valid |-> $past(credit_count) != '0)
	else begin
		assert_errors++;
		$error("command issued with zero credits on the previous cycle");
	end

	////////////////////
	// Response side
	////////////////////

	// Exactly the tag's class pulses, one cycle later, with its code
	done_route: assert property (@(posedge clock) disable iff (!rst_n)
		response_valid |=> done_vec == (4'b0001 << $past(resp_class)) &&
		done_code == $past(response_code))
	else begin
		assert_errors++;
		$error("done pulse or done code does not match the response");
	end

	// No pulse without a response
	done_source: assert property (@(posedge clock) disable iff (!rst_n)
		done_vec != '0 |-> $past(response_valid))
	else begin
		assert_errors++;
		$error("done pulse without a response on the previous cycle");
	end

	// Error code sets the class bit
	error_set: assert property (@(posedge clock) disable iff (!rst_n)
		response_valid && response_code != '0 |=>
		(response_error & (4'b0001 << $past(resp_class))) != '0)
	else begin
		assert_errors++;
		$error("non-zero response code did not set the class error bit");
	end

	// Sticky until reset
	error_sticky: assert property (@(posedge clock) disable iff (!rst_n)
		(~response_error & $past(response_error)) == '0)
	else begin
		assert_errors++;
		$error("a response error bit cleared without reset");
	end

endmodule

bind command_unit command_unit_chk chk (
	.clock          (clock),
	.rst_n          (rst_n),
	.command_valid  (command_valid),
	.command_tag    (command_tag),
	.credit_count   (credit_count),
	.response_valid (response_valid),
	.response_tag   (response_tag),
	.response_code  (response_code),
	.read_done      (read_done),
	.write_done     (write_done),
	.wed_done       (wed_done),
	.restart_done   (restart_done),
	.done_code      (done_code),
	.response_error (response_error),
	.wed_empty      (wed_empty),
	.restart_empty  (restart_empty)
);

// ==== verif/command_unit_tb.sv ====
`timescale 1ns/1ps

module command_unit_tb import cmd_pkg::*; ();

	localparam int stim_cycles    = 400;
	localparam int drain_cycles   = 200;
	// Whole run stays well inside this
	localparam int timeout_cycles = (stim_cycles + drain_cycles) * 2;

	logic                clock;
	logic                rst_n;
	logic                read_push, write_push, wed_push, restart_push;
	logic [opcode_w-1:0] read_opcode, write_opcode, wed_opcode, restart_opcode;
	logic [addr_w-1:0]   read_address, write_address, wed_address, restart_address;
	logic                read_full, write_full, wed_full, restart_full;
	logic                read_almost_full, write_almost_full;
	logic                wed_almost_full, restart_almost_full;
	logic                command_valid;
	logic [opcode_w-1:0] command_opcode;
	logic [addr_w-1:0]   command_address;
	logic [tag_w-1:0]    command_tag;
	logic                response_valid;
	logic [tag_w-1:0]    response_tag;
	logic [code_w-1:0]   response_code;
	logic [credit_w-1:0] response_credits;
	logic [credit_w-1:0] credit_count;
	logic                read_done, write_done, wed_done, restart_done;
	logic [code_w-1:0]   done_code;
	logic [3:0]          response_error;

	// Scoreboard and host model state
	logic [31:0]                rng;
	logic [opcode_w+addr_w-1:0] expected [4][$];
	logic [tag_w-1:0]           pending_tag [$];
	int                         pending_due [$];
	logic [credit_w-1:0]        exp_credits;
	logic [seq_w-1:0]           exp_seq;
	logic                       resp_prev;
	logic                       host_on;
	int                         cycle;
	int                         run_cycles = 0;
	int                         errors;

	command_unit dut (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Watchdog
	always @(posedge clock) begin
		run_cycles <= run_cycles + 1;
		if (run_cycles >= timeout_cycles) begin
			$display("run did not finish within %0d cycles", timeout_cycles);
			$display("errors: scoreboard %0d, assertions %0d", errors, dut.chk.assert_errors);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Entries each queue holds
	function automatic int queue_depth(input logic [class_w-1:0] cls);
		if (cls == cls_read || cls == cls_write)
			return bulk_depth;
		return ctrl_depth;
	endfunction

	task automatic compare(input string name, input logic [63:0] want, input logic [63:0] got);
		if (want !== got) begin
			$display("ERROR %0t %s expected %0h actual %0h", $time, name, want, got);
			errors++;
		end
	endtask

	// Random command into one queue and recorded unless the queue is full
	task automatic offer(input logic [class_w-1:0] cls);
		logic [opcode_w-1:0] op;
		logic [addr_w-1:0]   addr;
		logic                was_full;
		rng  = xorshift32(rng);
		op   = rng[opcode_w-1:0];
		rng  = xorshift32(rng);
		addr = rng;
		// Occupancy as tracked by the scoreboard
		was_full = (expected[cls].size() >= queue_depth(cls));
		case (cls)
			cls_read: begin
				read_push    = 1'b1;
				read_opcode  = op;
				read_address = addr;
			end
			cls_write: begin
				write_push    = 1'b1;
				write_opcode  = op;
				write_address = addr;
			end
			cls_wed: begin
				wed_push    = 1'b1;
				wed_opcode  = op;
				wed_address = addr;
			end
			cls_restart: begin
				restart_push    = 1'b1;
				restart_opcode  = op;
				restart_address = addr;
			end
		endcase
		if (!was_full)
			expected[cls].push_back({op, addr});
	endtask

	////////////////////
	// Scoreboard
	////////////////////

	// Full when no entry is free, almost full within the margin
	task automatic check_flags(input string name, input logic [class_w-1:0] cls,
		input logic is_full, input logic is_almost_full);
		int free_slots;
		free_slots = queue_depth(cls) - expected[cls].size();
		compare({name, "_full"}, 64'(free_slots == 0), 64'(is_full));
		compare({name, "_almost_full"}, 64'(free_slots <= almost_margin), 64'(is_almost_full));
	endtask

	task automatic check_cycle();
		logic [opcode_w+addr_w-1:0] want;
		logic [class_w-1:0]         cls;
		// Credit moves on the edge after a response or a grant
		if (resp_prev)
			exp_credits++;
		if (command_valid) begin
			exp_credits--;
			cls = command_tag[tag_w-1 -: class_w];
			if (expected[cls].size() == 0) begin
				$display("command of class %0d issued at %0t with no push pending", cls, $time);
				errors++;
			end else begin
				want = expected[cls].pop_front();
				compare("command_opcode", 64'(want[addr_w +: opcode_w]), 64'(command_opcode));
				compare("command_address", 64'(want[addr_w-1:0]), 64'(command_address));
			end
			compare("command_tag sequence", 64'(exp_seq), 64'(command_tag[seq_w-1:0]));
			exp_seq++;
			// Host answers after 1 to 16 cycles
			rng = xorshift32(rng);
			pending_tag.push_back(command_tag);
			pending_due.push_back(cycle + 1 + int'(rng[3:0]));
		end
		compare("credit_count", 64'(exp_credits), 64'(credit_count));
		// Waiting commands per class match the queue occupancy
		check_flags("read", cls_read, read_full, read_almost_full);
		check_flags("write", cls_write, write_full, write_almost_full);
		check_flags("wed", cls_wed, wed_full, wed_almost_full);
		check_flags("restart", cls_restart, restart_full, restart_almost_full);
	endtask

	// Host model answers in order with one credit each
	task automatic host_step();
		response_valid   = 1'b0;
		response_tag     = '0;
		response_code    = '0;
		response_credits = '0;
		if (host_on && pending_tag.size() != 0 && pending_due[0] <= cycle) begin
			rng              = xorshift32(rng);
			response_valid   = 1'b1;
			response_tag     = pending_tag.pop_front();
			pending_due.delete(0);
			// Roughly one error in eight
			response_code    = (rng[7:5] == 3'd0) ? (rng[15:8] | 8'h01) : '0;
			response_credits = 8'd1;
		end
		resp_prev = response_valid;
	endtask

	task automatic step();
		@(negedge clock);
		cycle++;
		read_push    = 1'b0;
		write_push   = 1'b0;
		wed_push     = 1'b0;
		restart_push = 1'b0;
		check_cycle();
		host_step();
	endtask

	function automatic logic drained();
		logic idle;
		idle = (pending_tag.size() == 0);
		for (int c = 0; c < 4; c++)
			if (expected[c].size() != 0)
				idle = 1'b0;
		return idle;
	endfunction

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		rng              = 32'h8efd_8694;
		rst_n            = 1'b0;
		read_push        = 1'b0;
		write_push       = 1'b0;
		wed_push         = 1'b0;
		restart_push     = 1'b0;
		read_opcode      = '0;
		write_opcode     = '0;
		wed_opcode       = '0;
		restart_opcode   = '0;
		read_address     = '0;
		write_address    = '0;
		wed_address      = '0;
		restart_address  = '0;
		response_valid   = 1'b0;
		response_tag     = '0;
		response_code    = '0;
		response_credits = '0;
		exp_credits      = credit_w'(init_credits);
		exp_seq          = '0;
		resp_prev        = 1'b0;
		host_on          = 1'b0;
		cycle            = 0;
		errors           = 0;
		repeat (16) @(negedge clock);
		rst_n = 1'b1;

		// Ten reads drain the credits while the host is silent
		for (int i = 0; i < 10; i++) begin
			step();
			offer(cls_read);
		end
		repeat (4) step();
		// Wed queue fills at two and later pushes drop
		for (int i = 0; i < 4; i++) begin
			step();
			offer(cls_wed);
		end
		step();
		offer(cls_restart);
		host_on = 1'b1;

		// Random traffic on all four queues
		for (int i = 0; i < stim_cycles; i++) begin
			step();
			rng = xorshift32(rng);
			if (rng[1:0] == 2'd0)
				offer(cls_read);
			if (rng[3:2] == 2'd0)
				offer(cls_write);
			if (rng[6:4] == 3'd0)
				offer(cls_wed);
			if (rng[10:7] == 4'd0)
				offer(cls_restart);
		end

		// Drain and let the last credit land
		while (!drained())
			step();
		repeat (2) step();
		compare("credit_count at end", 64'(init_credits), 64'(credit_count));

		$display("errors: scoreboard %0d, assertions %0d", errors, dut.chk.assert_errors);
		if (errors == 0 && dut.chk.assert_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== command_unit.f ====
verilog/cmd_pkg.sv
verilog/cmd_fifo.sv
verilog/cmd_arbiter.sv
verilog/credit_counter.sv
verilog/command_issue.sv
verilog/response_router.sv
verilog/command_unit.sv
verif/command_unit_chk.sv
verif/command_unit_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vcommand_unit_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "ALL CHECKS PASSED"

$(SIM): command_unit.f $(wildcard verilog/*.sv verif/*.sv)
	verilator --binary --assert --top-module command_unit_tb -f command_unit.f

clean:
	rm -rf obj_dir
